// ==== include/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// machine trap setup / handling
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// counters, read-only here
`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MCYCLEH     12'hB80
`define CSR_MINSTRETH   12'hB82

// MPP = 2'b11, machine mode only
`define MSTATUS_RESET   32'h1800

// environment call from M-mode
`define MCAUSE_ECALL    32'd11

// mstatus bit positions
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7

// only MIE and MPIE are writable
`define MSTATUS_WMASK   ((32'd1 << `MSTATUS_MIE) | (32'd1 << `MSTATUS_MPIE))

`endif

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_MRET
    } csr_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TRAP,
        ST_RET,
        ST_REDIRECT
    } trap_state_e;

    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] operand;
        logic [31:0] pc;
    } csr_cmd_t;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_write_t;

    // mstatus update needs its own strobe, it lands a cycle after the save
    typedef struct packed {
        logic        save;        // write mepc and mcause
        logic [31:0] epc;
        logic [31:0] cause;
        logic        mstatus_en;
        logic        mstatus_op;  // 0 enter trap, 1 return
    } trap_upd_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [31:0] rdata;
        logic        redirect;
        logic [31:0] redirect_pc;
    } csr_resp_t;

endpackage

// ==== rtl/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters (
    input  logic        clk,
    input  logic        reset,
    input  logic        retire,
    output logic [63:0] mcycle,
    output logic [63:0] minstret
);

    // free-running cycle count
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle <= 64'd0;
        end else begin
            mcycle <= mcycle + 64'd1;
        end
    end

    // one count per retire pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            minstret <= 64'd0;
        end else if (retire) begin
            minstret <= minstret + 64'd1;
        end
    end

endmodule

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic [11:0]         rd_addr,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::trap_upd_t  trap_upd,
    input  logic [63:0]         mcycle,
    input  logic [63:0]         minstret,
    output logic [31:0]         rd_data,
    output logic                rd_hit,
    output logic                rd_only,
    output logic [31:0]         mepc,
    output logic [31:0]         mtvec
);

    logic [31:0] mcause;
    logic [31:0] mstatus;

    always_ff @(posedge clk) begin
        if (reset) begin
            mepc    <= 32'd0;
            mcause  <= 32'd0;
            mstatus <= `MSTATUS_RESET;
            mtvec   <= 32'd0;
        end else begin
            if (trap_upd.save) begin // trap save wins over wr
                mepc   <= trap_upd.epc;
                mcause <= trap_upd.cause;
            end else if (wr.en && wr.addr == `CSR_MEPC) begin
                mepc <= wr.data;
            end else if (wr.en && wr.addr == `CSR_MCAUSE) begin
                mcause <= wr.data;
            end

            if (wr.en && wr.addr == `CSR_MTVEC)
                mtvec <= wr.data;

            if (trap_upd.mstatus_en) begin
                if (trap_upd.mstatus_op) begin // mret
                    mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
                    mstatus[`MSTATUS_MPIE] <= 1'b1;
                end else begin // ecall
                    mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
                    mstatus[`MSTATUS_MIE]  <= 1'b0;
                end
            end else if (wr.en && wr.addr == `CSR_MSTATUS) begin
                mstatus <= (mstatus & ~`MSTATUS_WMASK) | (wr.data & `MSTATUS_WMASK);
            end
        end
    end

    always_comb begin
        rd_data = 32'd0;
        rd_hit  = 1'b1;
        rd_only = 1'b0;
        case (rd_addr)
            `CSR_MSTATUS:   rd_data = mstatus;
            `CSR_MTVEC:     rd_data = mtvec;
            `CSR_MEPC:      rd_data = mepc;
            `CSR_MCAUSE:    rd_data = mcause;
            `CSR_MCYCLE: begin
                rd_data = mcycle[31:0];
                rd_only = 1'b1;
            end
            `CSR_MCYCLEH: begin
                rd_data = mcycle[63:32];
                rd_only = 1'b1;
            end
            `CSR_MINSTRET: begin
                rd_data = minstret[31:0];
                rd_only = 1'b1;
            end
            `CSR_MINSTRETH: begin
                rd_data = minstret[63:32];
                rd_only = 1'b1;
            end
            default:        rd_hit = 1'b0; // unimplemented csr
        endcase
    end

endmodule

// ==== rtl/trap_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module trap_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_cmd_t   cmd,
    input  logic [31:0]         rd_data,
    input  logic                rd_hit,
    input  logic                rd_only,
    input  logic [31:0]         mepc,
    input  logic [31:0]         mtvec,
    output csr_pkg::csr_write_t wr,
    output csr_pkg::trap_upd_t  trap_upd,
    output csr_pkg::csr_resp_t  resp,
    output logic                busy
);

    csr_pkg::trap_state_e state;
    csr_pkg::trap_state_e state_next;
    logic                 accept;
    logic                 is_csr_op;
    logic                 wants_write;
    logic                 illegal;
    logic [31:0]          new_val;
    logic                 ret_pending; // redirect to mepc, else mtvec

    assign busy   = (state != csr_pkg::ST_IDLE);
    assign accept = cmd.valid && !busy;

    // csr op decode and write value
    always_comb begin
        is_csr_op   = 1'b0;
        wants_write = 1'b0;
        new_val     = rd_data;
        case (cmd.op)
            csr_pkg::OP_CSRRW: begin
                is_csr_op   = 1'b1;
                wants_write = 1'b1;
                new_val     = cmd.operand;
            end
            csr_pkg::OP_CSRRS: begin
                is_csr_op   = 1'b1;
                wants_write = (cmd.operand != 32'd0);
                new_val     = rd_data | cmd.operand;
            end
            csr_pkg::OP_CSRRC: begin
                is_csr_op   = 1'b1;
                wants_write = (cmd.operand != 32'd0);
                new_val     = rd_data & ~cmd.operand;
            end
            default: ;
        endcase
    end

    assign illegal = !rd_hit || (rd_only && wants_write);

    assign wr.en   = accept && is_csr_op && wants_write && !illegal;
    assign wr.addr = cmd.addr;
    assign wr.data = new_val;

    assign trap_upd.save       = accept && (cmd.op == csr_pkg::OP_ECALL);
    assign trap_upd.epc        = cmd.pc + 32'd4;
    assign trap_upd.cause      = `MCAUSE_ECALL;
    assign trap_upd.mstatus_en = (state == csr_pkg::ST_TRAP) || (state == csr_pkg::ST_RET);
    assign trap_upd.mstatus_op = (state == csr_pkg::ST_RET);

    always_comb begin
        state_next = state;
        case (state)
            csr_pkg::ST_IDLE: begin
                if (accept && cmd.op == csr_pkg::OP_ECALL)
                    state_next = csr_pkg::ST_TRAP;
                else if (accept && cmd.op == csr_pkg::OP_MRET)
                    state_next = csr_pkg::ST_RET;
            end
            csr_pkg::ST_TRAP:     state_next = csr_pkg::ST_REDIRECT;
            csr_pkg::ST_RET:      state_next = csr_pkg::ST_REDIRECT;
            csr_pkg::ST_REDIRECT: state_next = csr_pkg::ST_IDLE;
            default:              state_next = csr_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= csr_pkg::ST_IDLE;
            ret_pending <= 1'b0;
            resp        <= '0;
        end else begin
            state <= state_next;
            resp  <= '0; // single-cycle pulse
            if (accept)
                ret_pending <= (cmd.op == csr_pkg::OP_MRET);
            if (accept && is_csr_op) begin
                resp.valid   <= 1'b1;
                resp.illegal <= illegal;
                resp.rdata   <= illegal ? 32'd0 : rd_data; // old value
            end
            if (state == csr_pkg::ST_REDIRECT) begin
                resp.valid       <= 1'b1;
                resp.redirect    <= 1'b1;
                resp.redirect_pc <= ret_pending ? mepc : {mtvec[31:2], 2'b00};
            end
        end
    end

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_cmd_t  cmd,
    input  logic               retire,
    output csr_pkg::csr_resp_t resp,
    output logic               busy
);

    csr_pkg::csr_write_t wr;
    csr_pkg::trap_upd_t  trap_upd;
    logic [31:0]         rd_data;
    logic                rd_hit;
    logic                rd_only;
    logic [31:0]         mepc;
    logic [31:0]         mtvec;
    logic [63:0]         mcycle;
    logic [63:0]         minstret;

    trap_ctrl u_trap_ctrl (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .rd_data  (rd_data),
        .rd_hit   (rd_hit),
        .rd_only  (rd_only),
        .mepc     (mepc),
        .mtvec    (mtvec),
        .wr       (wr),
        .trap_upd (trap_upd),
        .resp     (resp),
        .busy     (busy)
    );

    csr_counters u_csr_counters (
        .clk      (clk),
        .reset    (reset),
        .retire   (retire),
        .mcycle   (mcycle),
        .minstret (minstret)
    );

    csr_regfile u_csr_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_addr  (cmd.addr), // reads follow the incoming command
        .wr       (wr),
        .trap_upd (trap_upd),
        .mcycle   (mcycle),
        .minstret (minstret),
        .rd_data  (rd_data),
        .rd_hit   (rd_hit),
        .rd_only  (rd_only),
        .mepc     (mepc),
        .mtvec    (mtvec)
    );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

endmodule

// ==== tb/csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_unit_tb;

    logic               clk;
    logic               reset;
    logic               retire;
    csr_pkg::csr_cmd_t  cmd;
    csr_pkg::csr_resp_t resp;
    logic               busy;

    string       lines[$];
    int          num_tests = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          test_errs;
    integer      seed;
    logic [63:0] edge_count;
    logic [63:0] instret;
    logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause;

    tb_clock u_clock (.clk(clk));

    csr_unit UUT (
        .clk    (clk),
        .reset  (reset),
        .cmd    (cmd),
        .retire (retire),
        .resp   (resp),
        .busy   (busy)
    );

    always @(posedge clk) begin
        if (reset)
            edge_count <= 64'd0;
        else
            edge_count <= edge_count + 64'd1; // expected mcycle
    end

    task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr, output logic hit,
                                               output logic ro);
        hit = 1'b1;
        ro  = (addr[11:8] == 4'hB); // counter page
        case (addr)
            `CSR_MSTATUS:   return m_mstatus;
            `CSR_MTVEC:     return m_mtvec;
            `CSR_MEPC:      return m_mepc;
            `CSR_MCAUSE:    return m_mcause;
            `CSR_MCYCLE:    return edge_count[31:0];
            `CSR_MCYCLEH:   return edge_count[63:32];
            `CSR_MINSTRET:  return instret[31:0];
            `CSR_MINSTRETH: return instret[63:32];
            default:        hit = 1'b0;
        endcase
        return 32'd0;
    endfunction

    task automatic run_test(input int idx, input string line);
        string            op_s, addr_s, opnd_s, pc_s, ret_s, rdata_s, ill_s, redir_s;
        csr_pkg::csr_op_e op;
        logic [11:0]      addr;
        logic [31:0]      operand, pc, old, new_val, exp_rdata, exp_redir;
        logic             hit, ro, wants, exp_ill, is_trap;
        int               waited;
        void'($sscanf(line, "%s %s %s %s %s %s %s %s",
                      op_s, addr_s, opnd_s, pc_s, ret_s, rdata_s, ill_s, redir_s));
        case (op_s)
            "csrrw": op = csr_pkg::OP_CSRRW;
            "csrrs": op = csr_pkg::OP_CSRRS;
            "csrrc": op = csr_pkg::OP_CSRRC;
            "ecall": op = csr_pkg::OP_ECALL;
            default: op = csr_pkg::OP_MRET;
        endcase
        is_trap = (op == csr_pkg::OP_ECALL) || (op == csr_pkg::OP_MRET);
        addr = 12'(addr_s.atohex());
        pc = 32'(pc_s.atohex());
        if (opnd_s == "rand")
            operand = $random(seed);
        else
            operand = 32'(opnd_s.atohex());
        test_errs = 0;

        repeat (ret_s.atoi()) begin
            @(negedge clk);
            retire = 1'b1;
            instret = instret + 64'd1;
        end
        @(negedge clk);
        retire = 1'b0;

        old = model_read(addr, hit, ro);
        wants = (op == csr_pkg::OP_CSRRW) || (operand != 32'd0);
        exp_ill = !is_trap && (!hit || (ro && wants));
        exp_rdata = (is_trap || exp_ill) ? 32'd0 : old;
        exp_redir = 32'd0;
        if (op == csr_pkg::OP_ECALL) begin
            exp_redir = {m_mtvec[31:2], 2'b00};
            m_mepc = pc + 32'd4;
            m_mcause = `MCAUSE_ECALL;
            m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
            m_mstatus[`MSTATUS_MIE] = 1'b0;
        end else if (op == csr_pkg::OP_MRET) begin
            exp_redir = m_mepc;
            m_mstatus[`MSTATUS_MIE] = m_mstatus[`MSTATUS_MPIE];
            m_mstatus[`MSTATUS_MPIE] = 1'b1;
        end else if (!exp_ill && wants) begin
            if (op == csr_pkg::OP_CSRRW)
                new_val = operand;
            else if (op == csr_pkg::OP_CSRRS)
                new_val = old | operand;
            else
                new_val = old & ~operand;
            case (addr)
                `CSR_MSTATUS: begin
                    m_mstatus[`MSTATUS_MIE]  = new_val[`MSTATUS_MIE]; // only MIE and MPIE take
                    m_mstatus[`MSTATUS_MPIE] = new_val[`MSTATUS_MPIE];
                end
                `CSR_MTVEC:   m_mtvec = new_val;
                `CSR_MEPC:    m_mepc = new_val;
                default:      m_mcause = new_val;
            endcase
        end
        if (rdata_s != "model")
            exp_rdata = 32'(rdata_s.atohex());
        if (redir_s != "model" && redir_s != "-")
            exp_redir = 32'(redir_s.atohex());

        cmd.valid = 1'b1;
        cmd.op = op;
        cmd.addr = addr;
        cmd.operand = operand;
        cmd.pc = pc;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited == 1 && is_trap)
                check_value(32'(busy), 32'd1, "busy after trap accept");
            // stray mtvec write while busy should be dropped
            cmd.op = csr_pkg::OP_CSRRW;
            cmd.addr = `CSR_MTVEC;
            cmd.operand = 32'hffff_fff0;
            cmd.valid = is_trap;
        end while (!resp.valid && waited < 8);
        cmd = '0;

        if (!resp.valid) begin
            $display("test %0d: the DUT gave no response", idx);
            test_errs++;
        end else begin
            check_value(32'(waited), is_trap ? 32'd3 : 32'd1, "response latency");
            check_value(32'(resp.illegal), 32'(ill_s.atoi()), "illegal flag");
            check_value(resp.rdata, exp_rdata, "rdata");
            check_value(32'(resp.redirect), 32'(is_trap), "redirect flag");
            if (is_trap)
                check_value(resp.redirect_pc, exp_redir, "redirect_pc");
        end
        if (busy) begin
            $display("test %0d: busy did not drop after the response", idx);
            test_errs++;
        end
        @(negedge clk);
        check_value(32'(resp.valid), 32'd0, "resp.valid a cycle after the response");
        $display("test %0d %s %h: %s", idx, op_s, addr, (test_errs == 0) ? "pass" : "fail");
        errors += test_errs;
        if (test_errs != 0)
            failed_tests++;
    endtask

    initial begin
        int    fd;
        string line;
        seed = 32'h0c01289e;
        reset = 1'b1;
        retire = 1'b0;
        cmd = '0;
        instret = 64'd0;
        m_mstatus = `MSTATUS_RESET;
        m_mtvec = 32'd0;
        m_mepc = 32'd0;
        m_mcause = 32'd0;
        fd = $fopen("tb/csr_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/csr_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0)
                if (line.len() > 1 && line.getc(0) != "#")
                    lines.push_back(line);
            $fclose(fd);
        end
        num_tests = lines.size();
        if (num_tests == 0) begin
            $display("no tests were found in the tests file");
            errors++;
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (lines[i])
            run_test(i, lines[i]);

        $display("%0d tests run, %0d failed, %0d mismatches", num_tests, failed_tests, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        wait (num_tests > 0);
        #((num_tests * 20 + 16) * 4);
        $display("timeout: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== tb/csr_tests.txt ====
# op addr operand pc retires rdata illegal redirect
# rand = seeded operand, model = expected value from the testbench model, - = no redirect
csrrs 300 00000000 00000000 0 00001800 0 -
csrrs 341 00000000 00000000 0 00000000 0 -
csrrs 342 00000000 00000000 0 00000000 0 -
csrrs 305 00000000 00000000 0 00000000 0 -
csrrw 305 00001003 00000000 0 00000000 0 -
csrrs 305 00000010 00000000 0 00001003 0 -
csrrc 305 00000001 00000000 0 00001013 0 -
csrrc 305 00000000 00000000 0 00001012 0 -
csrrw 341 12345678 00000000 0 00000000 0 -
csrrs 341 00000000 00000000 0 12345678 0 -
csrrw 300 ffffffff 00000000 0 00001800 0 -
csrrs 300 00000000 00000000 0 00001888 0 -
ecall 000 00000000 00000200 0 00000000 0 00001010
csrrs 341 00000000 00000000 0 00000204 0 -
csrrs 342 00000000 00000000 0 0000000b 0 -
csrrs 300 00000000 00000000 0 00001880 0 -
csrrs 305 00000000 00000000 0 00001012 0 -
mret  000 00000000 00000000 0 00000000 0 00000204
csrrs 300 00000000 00000000 0 00001888 0 -
csrrs b02 00000000 00000000 5 00000005 0 -
csrrs b00 00000000 00000000 0 model 0 -
csrrs b80 00000000 00000000 0 model 0 -
csrrs 7c0 00000000 00000000 0 00000000 1 -
csrrw b00 00000001 00000000 0 00000000 1 -
csrrs b02 00000004 00000000 0 00000000 1 -
csrrs b02 00000000 00000000 0 00000005 0 -
csrrw 341 rand 00000000 0 model 0 -
csrrs 341 rand 00000000 0 model 0 -
csrrc 305 rand 00000000 0 model 0 -
ecall 000 00000000 00000400 0 00000000 0 model
mret  000 00000000 00000000 0 00000000 0 model
csrrs 300 00000000 00000000 0 model 0 -

// ==== compile.f ====
+incdir+include
rtl/csr_pkg.sv
rtl/csr_counters.sv
rtl/csr_regfile.sv
rtl/trap_ctrl.sv
rtl/csr_unit.sv
tb/tb_clock.sv
tb/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds and runs the csr_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module csr_unit_tb -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/csr_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
